/* build.f */
+incdir+include
hw/rvPkg.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/aluUnit.sv
hw/wordMemory.sv
hw/multiCycleCtrl.sv
hw/debugApbRegs.sv
hw/rvSystem.sv
testbench/rvSystem_sva.sv
testbench/rvSystemTb.sv

/* hw/aluUnit.sv */
`include "rvCore_defs.svh"

module aluUnit import rvPkg::*; (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  aluOpE               op,
    output logic [`RV_XLEN-1:0] result,
    output logic                zero
);

    always_comb begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluXor:  result = a ^ b;
            aluSrl:  result = a >> b[4:0];  // shamt from low bits
            default: result = a + b;
        endcase
    end

    // beq taken when the difference is zero
    assign zero = (result == '0);

endmodule

/* hw/debugApbRegs.sv */
`include "rvCore_defs.svh"

module debugApbRegs import rvPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  apbReqT              apbIn,
    output apbRspT              apbOut,
    input  statusT              status,
    input  logic [`RV_XLEN-1:0] pc,
    output dbgPortT             imemDbg,
    output dbgPortT             dmemDbg,
    input  logic [`RV_XLEN-1:0] dmemDbgData,
    output logic [4:0]          regSel,
    input  logic [`RV_XLEN-1:0] regDbgData,
    output logic                start
);

    localparam logic [11:0] baseImem = `RV_BASE_IMEM;
    localparam logic [11:0] baseDmem = `RV_BASE_DMEM;
    localparam logic [11:0] baseRegs = `RV_BASE_REGS;

    logic       access;
    logic       wr;
    logic       running;
    logic       ctrlHit;
    logic       inImem;
    logic       inDmem;
    logic       inRegs;
    logic [4:0] wordIdx;

    assign access  = apbIn.psel & apbIn.penable;  // access phase only
    assign wr      = apbIn.pwrite;
    assign running = status.running;
    assign ctrlHit = (apbIn.paddr == `RV_ADDR_CTRL);
    assign wordIdx = apbIn.paddr[6:2];
    assign inImem  = (apbIn.paddr[11:7] == baseImem[11:7]);
    assign inDmem  = (apbIn.paddr[11:7] == baseDmem[11:7]);
    assign inRegs  = (apbIn.paddr[11:7] == baseRegs[11:7]);

    always_comb begin
        apbOut.prdata  = '0;
        apbOut.pready  = 1'b1;  // no wait states
        apbOut.pslverr = 1'b0;
        if (access) begin
            if (ctrlHit) begin
                apbOut.pslverr = wr & running;
            end else if (apbIn.paddr == `RV_ADDR_STATUS) begin
                apbOut.pslverr = wr;
                apbOut.prdata  = `RV_XLEN'(status);
            end else if (apbIn.paddr == `RV_ADDR_PC) begin
                apbOut.pslverr = wr;
                apbOut.prdata  = pc;
            end else if (inImem) begin
                apbOut.pslverr = ~wr | running;  // write only
            end else if (inDmem) begin
                apbOut.pslverr = running;
                apbOut.prdata  = dmemDbgData;
            end else if (inRegs) begin
                apbOut.pslverr = wr;
                apbOut.prdata  = regDbgData;
            end else begin
                apbOut.pslverr = 1'b1;  // unmapped
            end
        end
    end

    assign imemDbg = '{we: access & wr & inImem & ~running, idx: wordIdx, wdata: apbIn.pwdata};
    assign dmemDbg = '{we: access & wr & inDmem & ~running, idx: wordIdx, wdata: apbIn.pwdata};
    assign regSel  = wordIdx;

    // one-cycle pulse after the ctrl write completes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start <= 1'b0;
        end else begin
            start <= access & wr & ctrlHit & apbIn.pwdata[0] & ~running;
        end
    end

endmodule

/* hw/instrDecoder.sv */
`include "rvCore_defs.svh"

module instrDecoder import rvPkg::*; (
    input  rvInstrT             instr,
    output ctrlT                ctrl,
    output logic [`RV_XLEN-1:0] imm
);

    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opBranch = 7'b1100011;

    logic legal;

    always_comb begin
        ctrl  = '0;
        imm   = '0;
        legal = 1'b1;
        case (instr.opcode)
            opLoad: begin  // lw
                imm            = {{20{instr.funct7[6]}}, instr.funct7, instr.rs2};
                ctrl.regWrite  = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                legal          = (instr.funct3 == 3'b010);
            end
            opStore: begin  // sw
                imm            = {{20{instr.funct7[6]}}, instr.funct7, instr.rd};
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                legal          = (instr.funct3 == 3'b010);
            end
            opImm: begin  // addi only
                imm            = {{20{instr.funct7[6]}}, instr.funct7, instr.rs2};
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                legal          = (instr.funct3 == 3'b000);
            end
            opReg: begin
                ctrl.regWrite = 1'b1;
                case ({instr.funct7, instr.funct3})
                    {7'b0100000, 3'b000}: ctrl.aluOp = aluSub;
                    {7'b0000000, 3'b100}: ctrl.aluOp = aluXor;
                    {7'b0000000, 3'b101}: ctrl.aluOp = aluSrl;
                    default:              legal      = 1'b0;
                endcase
            end
            opBranch: begin  // beq compares by subtraction
                imm         = {{19{instr.funct7[6]}}, instr.funct7[6], instr.rd[0],
                               instr.funct7[5:0], instr.rd[4:1], 1'b0};
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub;
                legal       = (instr.funct3 == 3'b000);
            end
            default: legal = 1'b0;
        endcase

        if (!legal) begin
            ctrl         = '0;  // nothing may write
            ctrl.illegal = 1'b1;
        end
    end

endmodule

/* hw/multiCycleCtrl.sv */
`include "rvCore_defs.svh"

module multiCycleCtrl import rvPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  rvInstrT             instrWord,
    input  ctrlT                ctrl,
    input  logic [`RV_XLEN-1:0] imm,
    input  logic                aluZero,
    output rvInstrT             instr,
    output logic [`RV_XLEN-1:0] pc,
    output logic                regWe,
    output logic                dmemWe,
    output statusT              status
);

    cpuStateE state;
    logic     branchTaken;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= stIdle;
            pc          <= '0;
            status      <= '0;
            branchTaken <= 1'b0;
        end else begin
            case (state)
                stIdle, stHalted: begin
                    if (start) begin
                        state  <= stFetch;
                        pc     <= '0;
                        status <= '{running: 1'b1, halted: 1'b0, illegal: 1'b0};
                    end
                end
                stFetch: state <= stDecode;
                stDecode: begin
                    // all-zero word ends the program, pc left pointing at it
                    if (instr == '0 || ctrl.illegal) begin
                        state          <= stHalted;
                        status.running <= 1'b0;
                        status.halted  <= 1'b1;
                        status.illegal <= (instr != '0);
                    end else begin
                        state <= stExecute;
                    end
                end
                stExecute: begin
                    branchTaken <= ctrl.branch & aluZero;
                    state       <= stMemory;
                end
                stMemory: state <= stWriteback;
                stWriteback: begin
                    pc    <= branchTaken ? pc + imm : pc + `RV_XLEN'(4);
                    state <= stFetch;
                end
                default: state <= stIdle;
            endcase
        end
    end

    // instruction register
    always_ff @(posedge clk) begin
        if (state == stFetch) begin
            instr <= instrWord;
        end
    end

    assign regWe  = (state == stWriteback) & ctrl.regWrite;
    assign dmemWe = (state == stMemory) & ctrl.memWrite;

endmodule

/* hw/regFile.sv */
`include "rvCore_defs.svh"

module regFile (
    input  logic                clk,
    input  logic                rst,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    input  logic [4:0]          rd,
    input  logic                we,
    input  logic [`RV_XLEN-1:0] wdata,
    output logic [`RV_XLEN-1:0] rdata1,
    output logic [`RV_XLEN-1:0] rdata2,
    input  logic [4:0]          dbgSel,
    output logic [`RV_XLEN-1:0] dbgData
);

    logic [`RV_XLEN-1:0] regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin  // x0 never written
            regs[rd] <= wdata;
        end
    end

    assign rdata1  = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2  = (rs2 == 5'd0) ? '0 : regs[rs2];
    assign dbgData = (dbgSel == 5'd0) ? '0 : regs[dbgSel];

endmodule

/* hw/rvPkg.sv */
`include "rvCore_defs.svh"

package rvPkg;

    // rv32 base encoding, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rvInstrT;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluXor,
        aluSrl
    } aluOpE;

    typedef struct packed {
        logic  regWrite;
        logic  memWrite;
        logic  memToReg;  // lw result instead of alu
        logic  aluSrcImm;
        logic  branch;
        aluOpE aluOp;
        logic  illegal;
    } ctrlT;

    typedef enum logic [2:0] {
        stIdle,
        stFetch,
        stDecode,
        stExecute,
        stMemory,
        stWriteback,
        stHalted
    } cpuStateE;

    typedef struct packed {
        logic running;
        logic halted;
        logic illegal;
    } statusT;

    typedef struct packed {
        logic [11:0]         paddr;
        logic                psel;
        logic                penable;
        logic                pwrite;
        logic [`RV_XLEN-1:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic [`RV_XLEN-1:0] prdata;
        logic                pready;
        logic                pslverr;
    } apbRspT;

    // host side access to either memory
    typedef struct packed {
        logic                we;
        logic [4:0]          idx;
        logic [`RV_XLEN-1:0] wdata;
    } dbgPortT;

endpackage

/* hw/rvSystem.sv */
`include "rvCore_defs.svh"

module rvSystem import rvPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  apbReqT apbIn,
    output apbRspT apbOut
);

    rvInstrT             instrWord;
    rvInstrT             instr;
    ctrlT                ctrl;
    statusT              status;
    dbgPortT             imemDbg;
    dbgPortT             dmemDbg;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] rdata1;
    logic [`RV_XLEN-1:0] rdata2;
    logic [`RV_XLEN-1:0] aluB;
    logic [`RV_XLEN-1:0] aluResult;
    logic [`RV_XLEN-1:0] dmemRdata;
    logic [`RV_XLEN-1:0] regWdata;
    logic [`RV_XLEN-1:0] dmemDbgData;
    logic [`RV_XLEN-1:0] regDbgData;
    logic [4:0]          regSel;
    logic                aluZero;
    logic                regWe;
    logic                dmemWe;
    logic                start;

    assign aluB     = ctrl.aluSrcImm ? imm : rdata2;
    assign regWdata = ctrl.memToReg ? dmemRdata : aluResult;

    multiCycleCtrl u_ctrl (
        .clk, .rst, .start, .instrWord, .ctrl, .imm, .aluZero,
        .instr, .pc, .regWe, .dmemWe, .status
    );

    instrDecoder u_decoder (.instr, .ctrl, .imm);

    regFile u_regFile (
        .clk, .rst, .rs1(instr.rs1), .rs2(instr.rs2), .rd(instr.rd),
        .we(regWe), .wdata(regWdata), .rdata1, .rdata2,
        .dbgSel(regSel), .dbgData(regDbgData)
    );

    aluUnit u_alu (.a(rdata1), .b(aluB), .op(ctrl.aluOp), .result(aluResult), .zero(aluZero));

    // program store, written by the host only
    wordMemory #(.payloadT(rvInstrT), .DEPTH(`RV_MEM_WORDS)) u_imem (
        .clk, .coreAddr(pc[6:2]), .coreWe(1'b0), .coreWdata('0),
        .coreRdata(instrWord), .dbg(imemDbg), .dbgRdata()
    );

    wordMemory #(.payloadT(logic [`RV_XLEN-1:0]), .DEPTH(`RV_MEM_WORDS)) u_dmem (
        .clk, .coreAddr(aluResult[6:2]), .coreWe(dmemWe), .coreWdata(rdata2),
        .coreRdata(dmemRdata), .dbg(dmemDbg), .dbgRdata(dmemDbgData)
    );

    debugApbRegs u_debug (
        .clk, .rst, .apbIn, .apbOut, .status, .pc, .imemDbg, .dmemDbg,
        .dmemDbgData, .regSel, .regDbgData, .start
    );

endmodule

/* hw/wordMemory.sv */
`include "rvCore_defs.svh"

module wordMemory import rvPkg::*; #(
    parameter type payloadT = logic [`RV_XLEN-1:0],
    parameter int  DEPTH    = `RV_MEM_WORDS
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] coreAddr,
    input  logic                     coreWe,
    input  payloadT                  coreWdata,
    output payloadT                  coreRdata,
    input  dbgPortT                  dbg,
    output payloadT                  dbgRdata
);

    payloadT mem [DEPTH];

    // core and host never write in the same cycle
    always_ff @(posedge clk) begin
        if (coreWe) begin
            mem[coreAddr] <= coreWdata;
        end
        if (dbg.we) begin
            mem[dbg.idx] <= payloadT'(dbg.wdata);
        end
    end

    assign coreRdata = mem[coreAddr];  // async read
    assign dbgRdata  = mem[dbg.idx];

endmodule

/* include/rvCore_defs.svh */
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// datapath width and memory size
`define RV_XLEN      32
`define RV_MEM_WORDS 32

// apb register offsets
`define RV_ADDR_CTRL   12'h000
`define RV_ADDR_STATUS 12'h004
`define RV_ADDR_PC     12'h008

// 32-word windows, 128 bytes each
`define RV_BASE_IMEM 12'h100
`define RV_BASE_DMEM 12'h200
`define RV_BASE_REGS 12'h300

`endif

/* run.sh */
#!/bin/sh
# build and run the rvSystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module rvSystemTb -o simv
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" sim.log; then
    exit 0
fi
exit 1

/* testbench/rvSystemTb.sv */
`include "rvCore_defs.svh"

module rvSystemTb import rvPkg::*; ();

    localparam int clkPeriod = 8;
    localparam int maxPolls  = 200;

    typedef enum logic [3:0] {
        cmdImem, cmdDmem, cmdStart, cmdWaitHalt, cmdReadReg,
        cmdReadData, cmdReadStatus, cmdReadPc, cmdBadWrite, cmdBadRead
    } cmdKindE;

    typedef struct packed {
        cmdKindE     kind;
        logic [11:0] addr;
        logic [31:0] value;  // write data or expected read value
    } cmdRowT;

    logic   clk;
    logic   rst;
    apbReqT apbIn;
    apbRspT apbOut;

    cmdRowT      cmdTable [$];
    logic [31:0] modelRegs [32];
    logic [31:0] modelDmem [32];
    logic [31:0] modelImem [32];
    logic [31:0] modelPc;
    statusT      modelStatus;
    logic [31:0] rngState = 32'd42521;
    int          instrCount = 0;
    int          watchLimit = 0;
    int          wordErrs = 0;
    int          statusErrs = 0;
    int          respErrs = 0;
    int          otherErrs = 0;

    rvSystem u_rvSystem (.clk, .rst, .apbIn, .apbOut);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [11:0] winAddr(input logic [11:0] base, input int idx);
        return base + 12'(idx * 4);
    endfunction

    // instruction encoders
    function automatic logic [31:0] rType(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] addiWord(input int rd, input int rs1, input int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i, 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
    endfunction

    function automatic logic [31:0] lwWord(input int rd, input int rs1, input int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i, 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
    endfunction

    function automatic logic [31:0] swWord(input int rs2, input int rs1, input int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] beqWord(input int rs1, input int rs2, input int imm);
        logic [12:0] i;
        i = 13'(imm);
        return {i[12], i[10:5], 5'(rs2), 5'(rs1), 3'b000, i[4:1], i[11], 7'b1100011};
    endfunction

    task automatic addRow(input cmdKindE k, input logic [11:0] a, input logic [31:0] v);
        cmdRowT r;
        r.kind  = k;
        r.addr  = a;
        r.value = v;
        cmdTable.push_back(r);
    endtask

    task automatic loadImem(input int idx, input logic [31:0] w);
        modelImem[idx] = w;
        addRow(cmdImem, winAddr(`RV_BASE_IMEM, idx), w);
    endtask

    // instruction-level reference from pc 0 up to a zero or unknown word
    task automatic runModel;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] ea;
        logic [31:0] res;
        logic [31:0] nextPc;
        logic        wrRd;
        logic        done;
        int          steps;
        modelPc = '0;
        done    = 1'b0;
        steps   = 0;
        while (!done && steps < 1000) begin
            w      = modelImem[modelPc[6:2]];
            a      = modelRegs[w[19:15]];
            b      = modelRegs[w[24:20]];
            immI   = {{20{w[31]}}, w[31:20]};
            res    = '0;
            wrRd   = 1'b1;
            nextPc = modelPc + 32'd4;
            casez ({w[31:25], w[14:12], w[6:0]})
                17'b???????_000_0010011: res = a + immI;  // addi
                17'b0100000_000_0110011: res = a - b;
                17'b0000000_100_0110011: res = a ^ b;
                17'b0000000_101_0110011: res = a >> b[4:0];
                17'b???????_010_0000011: begin  // lw
                    ea  = a + immI;
                    res = modelDmem[ea[6:2]];
                end
                17'b???????_010_0100011: begin  // sw
                    ea   = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    wrRd = 1'b0;
                    modelDmem[ea[6:2]] = b;
                end
                17'b???????_000_1100011: begin  // beq
                    wrRd = 1'b0;
                    if (a == b) begin
                        nextPc = modelPc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                default: begin
                    done        = 1'b1;
                    modelStatus = '{running: 1'b0, halted: 1'b1, illegal: (w != '0)};
                end
            endcase
            if (!done) begin
                if (wrRd && w[11:7] != 5'd0) begin
                    modelRegs[w[11:7]] = res;
                end
                modelPc = nextPc;
                instrCount++;
            end
            steps++;
        end
    endtask

    task automatic expectState;
        addRow(cmdReadStatus, `RV_ADDR_STATUS, 32'(modelStatus));
        addRow(cmdReadPc, `RV_ADDR_PC, modelPc);
        for (int i = 1; i < 16; i++) begin
            addRow(cmdReadReg, winAddr(`RV_BASE_REGS, i), modelRegs[i]);
        end
        for (int i = 0; i < 8; i++) begin
            addRow(cmdReadData, winAddr(`RV_BASE_DMEM, i), modelDmem[i]);
        end
    endtask

    task automatic buildTable;
        logic [31:0] prog [17];
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
            modelImem[i] = '0;
        end
        addRow(cmdReadStatus, `RV_ADDR_STATUS, 32'd0);
        addRow(cmdReadPc, `RV_ADDR_PC, 32'd0);
        addRow(cmdBadRead, 12'h00c, 32'd0);  // outside the map
        for (int i = 0; i < 32; i++) begin
            rngState     = xorshift32(rngState);
            modelDmem[i] = rngState;
            addRow(cmdDmem, winAddr(`RV_BASE_DMEM, i), rngState);
        end
        addRow(cmdReadData, winAddr(`RV_BASE_DMEM, 3), modelDmem[3]);

        prog[0]  = addiWord(1, 0, 100);
        prog[1]  = addiWord(2, 0, -7);
        prog[2]  = rType(7'h20, 2, 1, 3'b000, 3);  // sub x3, x1, x2
        prog[3]  = rType(7'h00, 2, 3, 3'b100, 4);  // xor x4, x3, x2
        prog[4]  = addiWord(9, 0, 3);
        prog[5]  = rType(7'h00, 9, 2, 3'b101, 5);  // srl x5, x2, x9
        prog[6]  = lwWord(6, 0, 8);
        prog[7]  = lwWord(7, 0, 12);
        prog[8]  = rType(7'h00, 7, 6, 3'b100, 8);
        prog[9]  = swWord(8, 0, 16);
        prog[10] = swWord(4, 9, 21);               // word 6
        prog[11] = beqWord(1, 2, 8);               // not taken
        prog[12] = addiWord(10, 0, 1);
        prog[13] = beqWord(10, 10, 8);             // taken so the next one is skipped
        prog[14] = addiWord(11, 0, 55);
        prog[15] = addiWord(12, 1, 1);
        prog[16] = '0;
        for (int i = 0; i < 17; i++) begin
            loadImem(i, prog[i]);
        end
        addRow(cmdStart, `RV_ADDR_CTRL, 32'd1);
        addRow(cmdBadWrite, `RV_ADDR_CTRL, 32'd1);
        addRow(cmdBadWrite, winAddr(`RV_BASE_DMEM, 5), 32'hdeadbeef);
        addRow(cmdBadRead, winAddr(`RV_BASE_DMEM, 5), 32'd0);
        addRow(cmdWaitHalt, 12'h000, 32'd0);
        runModel();
        expectState();
        addRow(cmdBadRead, winAddr(`RV_BASE_IMEM, 0), 32'd0);  // write only window

        // second run stops on an unknown R-type encoding
        loadImem(0, addiWord(13, 0, 77));
        loadImem(1, rType(7'h20, 2, 1, 3'b100, 14));
        loadImem(2, addiWord(15, 0, 9));
        addRow(cmdStart, `RV_ADDR_CTRL, 32'd1);
        addRow(cmdWaitHalt, 12'h000, 32'd0);
        runModel();
        expectState();
    endtask

    task automatic apbAccess(input logic write, input logic [11:0] addr,
                             input logic [31:0] wdata, output apbRspT rsp);
        @(negedge clk);
        apbIn.paddr   = addr;
        apbIn.psel    = 1'b1;
        apbIn.penable = 1'b0;
        apbIn.pwrite  = write;
        apbIn.pwdata  = wdata;
        @(negedge clk);
        apbIn.penable = 1'b1;
        #(clkPeriod / 4);  // sample mid low phase
        rsp = apbOut;
        @(negedge clk);
        apbIn = '0;
    endtask

    task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data, output apbRspT rsp);
        apbAccess(1'b1, addr, data, rsp);
    endtask

    task automatic apbRead(input logic [11:0] addr, output apbRspT rsp);
        apbAccess(1'b0, addr, '0, rsp);
    endtask

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %h expected %h", $time, name, got, exp);
            wordErrs++;
        end
    endtask

    task automatic checkStatus(input string name, input statusT got, input statusT exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %b expected %b", $time, name, got, exp);
            statusErrs++;
        end
    endtask

    task automatic checkResp(input string name, input apbRspT got, input logic errExp);
        if (got.pready !== 1'b1 || got.pslverr !== errExp) begin
            $display("ERR %0t %s: got pready=%b pslverr=%b expected pready=1 pslverr=%b",
                     $time, name, got.pready, got.pslverr, errExp);
            respErrs++;
        end
    endtask

    task automatic waitHalt;
        apbRspT rsp;
        statusT st;
        int     polls;
        st    = '0;
        polls = 0;
        while (!st.halted && polls < maxPolls) begin
            apbRead(`RV_ADDR_STATUS, rsp);
            st = statusT'(rsp.prdata[2:0]);
            polls++;
        end
        if (!st.halted) begin
            $display("core did not halt within %0d status polls", maxPolls);
            otherErrs++;
        end
    endtask

    initial begin
        wait (watchLimit > 0);
        repeat (watchLimit) @(posedge clk);
        $display("watchdog expired after %0d cycles", watchLimit);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        cmdRowT row;
        apbRspT rsp;
        string  name;
        apbIn = '0;
        rst   = 1'b1;
        buildTable();
        watchLimit = 16 + instrCount * 5 + cmdTable.size() * 4 + 200;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < cmdTable.size(); i++) begin
            row  = cmdTable[i];
            name = $sformatf("prdata@%03h", row.addr);
            case (row.kind)
                cmdImem, cmdDmem, cmdStart: begin
                    apbWrite(row.addr, row.value, rsp);
                    checkResp("pslverr", rsp, 1'b0);
                end
                cmdBadWrite: begin
                    apbWrite(row.addr, row.value, rsp);
                    checkResp("pslverr", rsp, 1'b1);
                end
                cmdBadRead: begin
                    apbRead(row.addr, rsp);
                    checkResp("pslverr", rsp, 1'b1);
                end
                cmdWaitHalt: waitHalt();
                cmdReadStatus: begin
                    apbRead(row.addr, rsp);
                    checkResp("pslverr", rsp, 1'b0);
                    checkStatus("status", statusT'(rsp.prdata[2:0]), statusT'(row.value[2:0]));
                end
                default: begin
                    apbRead(row.addr, rsp);
                    checkResp("pslverr", rsp, 1'b0);
                    checkWord(name, rsp.prdata, row.value);
                end
            endcase
        end

        $display("errors: word %0d, status %0d, response %0d, other %0d",
                 wordErrs, statusErrs, respErrs, otherErrs);
        if (wordErrs + statusErrs + respErrs + otherErrs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* testbench/rvSystem_sva.sv */
`include "rvCore_defs.svh"

module rvSystemSva import rvPkg::*; (
    input logic                clk,
    input logic                rst,
    input apbReqT              apbIn,
    input apbRspT              apbOut,
    input dbgPortT             imemDbg,
    input dbgPortT             dmemDbg,
    input statusT              status,
    input logic [`RV_XLEN-1:0] pc,
    input cpuStateE            state,
    input logic                regWe,
    input logic                dmemWe
);

    // no wait states and no memory write on a rejected access
    assert property (@(posedge clk) disable iff (rst)
        (apbIn.psel && apbIn.penable) |->
            (apbOut.pready && !(apbOut.pslverr && (imemDbg.we || dmemDbg.we))))
        else $error("pready low or a rejected apb access wrote a memory");

    assert property (@(posedge clk) disable iff (rst)
        regWe |-> (state == stWriteback && status.running))
        else $error("register write outside writeback of a running core");

    assert property (@(posedge clk) disable iff (rst)
        dmemWe |-> (state == stMemory && status.running))
        else $error("data memory write outside memory state of a running core");

    // pc holds the fetched address until writeback
    assert property (@(posedge clk) disable iff (rst)
        (state == stFetch) |=> (state == stDecode && $stable(pc)))
        else $error("fetch not followed by decode at the same pc");

endmodule

// each instance ties off the inputs its block does not have
bind debugApbRegs rvSystemSva u_apbSva (
    .clk, .rst, .apbIn, .apbOut, .imemDbg, .dmemDbg, .status, .pc,
    .state(rvPkg::stIdle), .regWe(1'b0), .dmemWe(1'b0)
);

bind multiCycleCtrl rvSystemSva u_ctrlSva (
    .clk, .rst, .apbIn('0), .apbOut('0), .imemDbg('0), .dmemDbg('0), .status, .pc,
    .state, .regWe, .dmemWe
);
